// ==== source/fetch_pkg.sv ====
// ####################
// shared types and constants for the instruction fetch front end
// import into a module body, use scoped names in port lists
// ####################

package fetch_pkg;

    // basic widths
    localparam int xlen_w    = 32;
    localparam int reg_idx_w = 5;
    localparam int opcode_w  = 7;

    // instruction field positions (RV32I base formats)
    localparam int opcode_lsb = 0;
    localparam int rs1_lsb    = 15;
    localparam int rs2_lsb    = 20;

    typedef logic [xlen_w-1:0]    xlen_t;    // address or instruction word
    typedef logic [reg_idx_w-1:0] reg_idx_t; // x0..x31

    localparam xlen_t nop_instr   = 32'h0000_0013; // addi x0,x0,0
    localparam xlen_t instr_bytes = 32'd4;         // fixed 32-bit encoding

    // major opcodes seen by the front end
    typedef enum logic [opcode_w-1:0] {
        op_jal    = 7'b110_1111,
        op_jalr   = 7'b110_0111,
        op_branch = 7'b110_0011,
        op_load   = 7'b000_0011,
        op_other  = 7'b001_0011
    } opcode_e;

    // next pc source
    typedef enum logic [1:0] {
        sel_seq   = 2'd0, // iaddr + 4
        sel_hold  = 2'd1,
        sel_early = 2'd2, // jal seen in if/id
        sel_late  = 2'd3  // redirect from execute
    } pc_sel_e;

    // what the if/id register does on the next edge
    typedef enum logic [1:0] {
        ifid_load   = 2'd0,
        ifid_hold   = 2'd1,
        ifid_bubble = 2'd2
    } ifid_op_e;

    typedef struct packed {
        pc_sel_e  pc_sel;
        ifid_op_e ifid_op;
    } fetch_ctrl_t;

    typedef struct packed {
        xlen_t instr;
        xlen_t pc;
        xlen_t pc_plus4;
    } ifid_t;

endpackage

// ==== source/fetch_ctrl.sv ====
// ####################
// fetch control, combinational
// picks advance, hold, redirect or squash for pc_gen and ifid_reg
// ####################

`timescale 1ns/10ps

module fetch_ctrl (
    input  logic                  early_hit,     // jal sitting in if/id
    input  logic                  late_redirect, // taken branch or jalr in execute
    input  logic                  iready_n,      // low when idata is valid
    input  logic                  ex_load,
    input  fetch_pkg::reg_idx_t   ex_rd,
    input  fetch_pkg::reg_idx_t   rs1,
    input  fetch_pkg::reg_idx_t   rs2,
    output fetch_pkg::fetch_ctrl_t ctrl
);

    import fetch_pkg::*;

    logic rd_nonzero;
    logic rd_match;
    logic load_use;

    // load-use hazard against the instruction in if/id
    assign rd_nonzero = (ex_rd != '0);     // x0 never creates a dependency
    assign rd_match   = (ex_rd == rs1) || (ex_rd == rs2);
    assign load_use   = ex_load && rd_nonzero && rd_match;

    // priority encoder, first match wins
    always_comb begin
        ctrl.pc_sel  = sel_seq;
        ctrl.ifid_op = ifid_load;

        if (late_redirect) begin
            // wrong path in if/id and at iaddr, throw it away
            ctrl.pc_sel  = sel_late;
            ctrl.ifid_op = ifid_bubble;
        end else if (load_use) begin
            // freeze the front end, word at iaddr is fetched again
            ctrl.pc_sel  = sel_hold;
            ctrl.ifid_op = ifid_hold;
        end else if (early_hit) begin
            ctrl.pc_sel  = sel_early;
            ctrl.ifid_op = ifid_bubble; // squash fall-through
        end else if (iready_n) begin
            // memory not ready
            ctrl.pc_sel  = sel_hold;
            ctrl.ifid_op = ifid_bubble;
        end else begin
            ctrl.pc_sel  = sel_seq;
            ctrl.ifid_op = ifid_load;
        end
    end

endmodule

// ==== source/pc_gen.sv ====
// ####################
// program counter and next fetch address
// drives iaddr to instruction memory, also gives iaddr + 4 to if/id
// ####################

`timescale 1ns/10ps

module pc_gen #(
    parameter fetch_pkg::xlen_t reset_pc = 32'h0001_0000
) (
    input  logic                   clk,
    input  logic                   rst,
    input  fetch_pkg::fetch_ctrl_t ctrl,
    input  fetch_pkg::xlen_t       early_target, // from jal predecode
    input  fetch_pkg::xlen_t       late_target,  // from execute
    output fetch_pkg::xlen_t       iaddr,
    output fetch_pkg::xlen_t       iaddr_plus4
);

    import fetch_pkg::*;

    xlen_t pc_q;
    xlen_t pc_d;
    xlen_t pc_inc;

    // single adder, shared with the if/id pc_plus4 field
    assign pc_inc = pc_q + instr_bytes;

    // next address select
    always_comb begin
        case (ctrl.pc_sel)
            sel_seq: begin
                pc_d = pc_inc;
            end
            sel_hold: begin
                pc_d = pc_q; // stall or memory wait
            end
            sel_early: begin
                pc_d = early_target;
            end
            sel_late: begin
                pc_d = late_target;
            end
            default: begin
                pc_d = pc_q;
            end
        endcase
    end

    // pc register
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            pc_q <= reset_pc;
        end else begin
            pc_q <= pc_d;
        end
    end

    // memory answers in the same cycle
    assign iaddr       = pc_q;
    assign iaddr_plus4 = pc_inc;

endmodule

// ==== source/ifid_reg.sv ====
// ####################
// IF/ID pipeline register
// loads the fetched word with its pc, holds, or inserts a nop bubble
// ####################

`timescale 1ns/10ps

module ifid_reg #(
    parameter fetch_pkg::xlen_t reset_pc = 32'h0001_0000
) (
    input  logic                   clk,
    input  logic                   rst,
    input  fetch_pkg::fetch_ctrl_t ctrl,
    input  fetch_pkg::xlen_t       idata,       // word returned for iaddr
    input  fetch_pkg::xlen_t       iaddr,
    input  fetch_pkg::xlen_t       iaddr_plus4,
    output fetch_pkg::ifid_t       ifid
);

    import fetch_pkg::*;

    ifid_t fetched;
    ifid_t bubble;

    assign fetched = '{instr: idata, pc: iaddr, pc_plus4: iaddr_plus4};

    // bubble keeps the current address so pc tracking stays sane downstream
    assign bubble = '{instr: nop_instr, pc: iaddr, pc_plus4: iaddr_plus4};

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            ifid.instr    <= nop_instr;
            ifid.pc       <= reset_pc;
            ifid.pc_plus4 <= reset_pc + instr_bytes;
        end else begin
            case (ctrl.ifid_op)
                ifid_load: begin
                    ifid <= fetched;
                end
                ifid_bubble: begin
                    ifid <= bubble;
                end
                default: begin
                    ifid <= ifid; // load-use hold
                end
            endcase
        end
    end

endmodule

// ==== source/jal_predecode.sv ====
// ####################
// early decode of the word in IF/ID
// flags JAL and builds its target, slices rs1/rs2 for the hazard check
// ####################

`timescale 1ns/10ps

module jal_predecode (
    input  fetch_pkg::ifid_t     ifid,
    output logic                 early_hit,
    output fetch_pkg::xlen_t     early_target,
    output fetch_pkg::reg_idx_t  rs1,
    output fetch_pkg::reg_idx_t  rs2
);

    import fetch_pkg::*;

    logic [opcode_w-1:0] opcode;
    xlen_t               instr;
    xlen_t               j_imm;

    assign instr  = ifid.instr;
    assign opcode = instr[opcode_lsb +: opcode_w];

    // only jal has its target known here, jalr waits for execute
    assign early_hit = (opcode == op_jal);

    // J-type immediate, bit 0 always zero
    assign j_imm = {
        {12{instr[31]}}, // sign
        instr[19:12],
        instr[20],
        instr[30:21],
        1'b0
    };

    assign early_target = ifid.pc + j_imm;

    // source fields, meaningless for jal but harmless to compare
    assign rs1 = instr[rs1_lsb +: reg_idx_w];
    assign rs2 = instr[rs2_lsb +: reg_idx_w];

endmodule

// ==== source/fetch_stage.sv ====
// ####################
// instruction fetch front end, top level
// connect iaddr/idata to the instruction memory and ifid to decode
// late_redirect and ex_load/ex_rd come from the execute stage
// ####################

`timescale 1ns/10ps

module fetch_stage #(
    parameter fetch_pkg::xlen_t reset_pc = 32'h0001_0000
) (
    input  logic                clk,
    input  logic                rst,

    // instruction memory
    input  fetch_pkg::xlen_t    idata,
    input  logic                iready_n,    // active low, data valid
    output fetch_pkg::xlen_t    iaddr,

    // execute stage
    input  logic                late_redirect,
    input  fetch_pkg::xlen_t    late_target,
    input  logic                ex_load,     // load in execute
    input  fetch_pkg::reg_idx_t ex_rd,

    // decode
    output fetch_pkg::ifid_t    ifid,
    output fetch_pkg::reg_idx_t rs1_early,
    output fetch_pkg::reg_idx_t rs2_early
);

    import fetch_pkg::*;

    fetch_ctrl_t ctrl;
    xlen_t       iaddr_plus4;
    logic        early_hit;
    xlen_t       early_target;

    fetch_ctrl u_fetch_ctrl (
        .early_hit     (early_hit),
        .late_redirect (late_redirect),
        .iready_n      (iready_n),
        .ex_load       (ex_load),
        .ex_rd         (ex_rd),
        .rs1           (rs1_early),
        .rs2           (rs2_early),
        .ctrl          (ctrl)
    );

    pc_gen #(
        .reset_pc (reset_pc)
    ) u_pc_gen (
        .clk          (clk),
        .rst          (rst),
        .ctrl         (ctrl),
        .early_target (early_target),
        .late_target  (late_target),
        .iaddr        (iaddr),
        .iaddr_plus4  (iaddr_plus4)
    );

    // captures what memory returned for the current iaddr
    ifid_reg #(
        .reset_pc (reset_pc)
    ) u_ifid_reg (
        .clk         (clk),
        .rst         (rst),
        .ctrl        (ctrl),
        .idata       (idata),
        .iaddr       (iaddr),
        .iaddr_plus4 (iaddr_plus4),
        .ifid        (ifid)
    );

    jal_predecode u_jal_predecode (
        .ifid         (ifid),
        .early_hit    (early_hit),
        .early_target (early_target),
        .rs1          (rs1_early),
        .rs2          (rs2_early)
    );

endmodule

// ==== test/tb_fetch_stage.sv ====
// ####################
// testbench for the fetch front end
// models the instruction memory, drives random and directed traffic,
// and checks iaddr and IF/ID against a cycle model each clock
// ####################

`timescale 1ns/10ps

module tb_fetch_stage;

    import fetch_pkg::*;

    localparam xlen_t reset_pc  = 32'h0001_0000;
    localparam int    mem_words = 64;

    // run length of each section in cycles
    localparam int n_reset     = 4;
    localparam int n_random    = 300;
    localparam int n_gap       = 12;
    localparam int n_loaduse   = 8;
    localparam int n_redir     = 10;
    localparam int n_tail      = 4;
    localparam int stim_cycles = n_reset + n_random + (n_gap + 3) + (n_loaduse + 2)
                                 + n_redir + n_tail;
    localparam int cycle_limit = 2 * stim_cycles + 50;

    // fetch pc and IF/ID plus the jal info of the held word
    typedef struct packed {
        xlen_t pc;
        ifid_t ifid;
        logic  jal;
        xlen_t jal_off;
    } model_t;

    logic     clk;
    logic     rst;
    xlen_t    idata;
    logic     iready_n;
    xlen_t    iaddr;
    logic     late_redirect;
    xlen_t    late_target;
    logic     ex_load;
    reg_idx_t ex_rd;
    ifid_t    ifid;
    reg_idx_t rs1_early;
    reg_idx_t rs2_early;

    xlen_t  mem [mem_words];
    logic   is_jal [mem_words];
    xlen_t  jal_off [mem_words];
    xlen_t  word_off;
    model_t model;
    logic [31:0] lcg_state = 32'd20;
    int     errors      = 0;
    int     checks      = 0;
    int     cycle_count = 0;

    fetch_stage #(
        .reset_pc (reset_pc)
    ) dut_i (
        .clk           (clk),
        .rst           (rst),
        .idata         (idata),
        .iready_n      (iready_n),
        .iaddr         (iaddr),
        .late_redirect (late_redirect),
        .late_target   (late_target),
        .ex_load       (ex_load),
        .ex_rd         (ex_rd),
        .ifid          (ifid),
        .rs1_early     (rs1_early),
        .rs2_early     (rs2_early)
    );

    // memory answers in the same cycle and returns junk while not ready
    assign word_off = (iaddr - reset_pc) >> 2;
    assign idata    = iready_n ? 32'hbad0_0bad : mem[word_off[5:0]];

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [5:0] word_index(input xlen_t addr);
        xlen_t off;
        off = (addr - reset_pc) >> 2;
        return off[5:0]; // memory aliases every 64 words
    endfunction

    // J-type encoding with imm[20|10:1|11|19:12] above rd
    function automatic xlen_t jal_word(input int off, input reg_idx_t rd);
        logic [20:0] imm;
        imm = off[20:0];
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
    endfunction

    function automatic model_t bubble_of(input model_t m);
        model_t n;
        n         = m;
        n.ifid    = '{instr: nop_instr, pc: m.pc, pc_plus4: m.pc + 32'd4};
        n.jal     = 1'b0;
        n.jal_off = '0;
        return n;
    endfunction

    // one clock of the fetch rules with late redirect first and plain advance last
    function automatic model_t ref_step(input model_t m, input logic rdy_n,
                                        input logic late, input xlen_t late_pc,
                                        input logic ld, input reg_idx_t ld_rd);
        model_t     n;
        logic       hazard;
        logic [5:0] idx;
        hazard = ld && (ld_rd != 5'd0)
                 && (ld_rd == m.ifid.instr[19:15] || ld_rd == m.ifid.instr[24:20]);
        idx    = word_index(m.pc);
        if (late) begin
            n    = bubble_of(m);
            n.pc = late_pc;
        end else if (hazard) begin
            n = m; // everything frozen
        end else if (m.jal) begin
            n    = bubble_of(m);
            n.pc = m.ifid.pc + m.jal_off;
        end else if (rdy_n) begin
            n = bubble_of(m); // pc stays
        end else begin
            n.ifid    = '{instr: mem[idx], pc: m.pc, pc_plus4: m.pc + 32'd4};
            n.jal     = is_jal[idx];
            n.jal_off = jal_off[idx];
            n.pc      = m.pc + 32'd4;
        end
        return n;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] want);
        checks++;
        if (got !== want) begin
            $display("** Error at %0t: %s is %h, expected %h", $time, what, got, want);
            errors++;
        end
    endtask

    task automatic fill_memory();
        logic [31:0] r;
        int          t;
        int          off;
        for (int i = 0; i < mem_words; i++) begin
            r = next_rand();
            if (r[31:29] == 3'd0) begin
                t = next_rand() >> 26; // target word inside the array
                if (t == i) begin
                    t = (i + 1) % mem_words;
                end
                off        = (t - i) * 4;
                mem[i]     = jal_word(off, r[11:7]);
                is_jal[i]  = 1'b1;
                jal_off[i] = off;
            end else begin
                mem[i]     = {r[31:7], op_other};
                is_jal[i]  = 1'b0;
                jal_off[i] = '0;
            end
        end
        // known jal at word 3 for the redirect section
        mem[3]     = jal_word(37 * 4, 5'd1);
        is_jal[3]  = 1'b1;
        jal_off[3] = 37 * 4;
    endtask

    task automatic next_slot();
        @(posedge clk);
        #10;
    endtask

    task automatic drive_inputs(input logic rdy_n, input logic late, input xlen_t late_pc,
                                input logic ld, input reg_idx_t ld_rd);
        iready_n      = rdy_n;
        late_redirect = late;
        late_target   = late_pc;
        ex_load       = ld;
        ex_rd         = ld_rd;
    endtask

    // model steps on each edge and compares once outputs settle
    initial begin
        forever begin
            @(posedge clk);
            if (!rst) begin
                model.pc      = reset_pc;
                model.ifid    = '{instr: nop_instr, pc: reset_pc, pc_plus4: reset_pc + 32'd4};
                model.jal     = 1'b0;
                model.jal_off = '0;
            end else begin
                model = ref_step(model, iready_n, late_redirect, late_target, ex_load, ex_rd);
            end
            #1;
            check_value("iaddr", iaddr, model.pc);
            check_value("ifid.instr", ifid.instr, model.ifid.instr);
            check_value("ifid.pc", ifid.pc, model.ifid.pc);
            check_value("ifid.pc_plus4", ifid.pc_plus4, model.ifid.pc_plus4);
            check_value("rs1_early", 32'(rs1_early), 32'(model.ifid.instr[19:15]));
            check_value("rs2_early", 32'(rs2_early), 32'(model.ifid.instr[24:20]));
        end
    end

    initial begin
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run still going after %0d clock cycles", cycle_limit);
        $display("sim failed");
        $finish;
    end

    initial begin
        logic [31:0] r;
        logic [31:0] r2;
        rst = 1'b0;
        drive_inputs(1'b0, 1'b0, reset_pc, 1'b0, 5'd0);
        fill_memory();
        repeat (n_reset) @(posedge clk);
        #10;
        rst = 1'b1;

        // random traffic at low event rates
        repeat (n_random) begin
            next_slot();
            r  = next_rand();
            r2 = next_rand();
            drive_inputs(r[31:28] < 4'd3, r[27:24] == 4'd0,
                         reset_pc + {r2[25:20], 2'b00}, r[23:21] == 3'd0,
                         r2[31] ? model.ifid.instr[19:15] : r2[30:26]);
        end

        // long memory wait and then resume
        repeat (n_gap) begin
            next_slot();
            drive_inputs(1'b1, 1'b0, reset_pc, 1'b0, 5'd0);
        end
        repeat (3) begin
            next_slot();
            drive_inputs(1'b0, 1'b0, reset_pc, 1'b0, 5'd0);
        end

        // load in execute vs the word in IF/ID
        for (int k = 0; k < n_loaduse; k++) begin
            next_slot();
            case (k % 4)
                0: drive_inputs(1'b0, 1'b0, reset_pc, 1'b1, model.ifid.instr[19:15]);
                1: drive_inputs(1'b0, 1'b0, reset_pc, 1'b1, 5'd0); // x0 never stalls
                2: drive_inputs(1'b0, 1'b0, reset_pc, 1'b1, model.ifid.instr[24:20]);
                default: drive_inputs(1'b0, 1'b0, reset_pc, 1'b0, 5'd0);
            endcase
        end
        repeat (2) begin
            next_slot();
            drive_inputs(1'b0, 1'b0, reset_pc, 1'b0, 5'd0);
        end

        // steer to the jal at word 3 and redirect late while it sits in IF/ID
        for (int k = 0; k < 2; k++) begin
            next_slot();
            drive_inputs(1'b0, 1'b1, reset_pc + 32'd12, 1'b0, 5'd0);
            next_slot();
            drive_inputs(1'b0, 1'b0, reset_pc, 1'b0, 5'd0);
            next_slot();
            if (ifid.instr[6:0] != op_jal || ifid.pc != reset_pc + 32'd12) begin
                $display("redirect section: JAL did not reach IF/ID before the late redirect");
                errors++;
            end
            drive_inputs(1'b0, 1'b1, reset_pc + 32'd80 + 32'(k * 40), 1'b0, 5'd0);
            next_slot();
            drive_inputs(1'b0, 1'b0, reset_pc, 1'b0, 5'd0);
        end
        repeat (n_redir - 8) begin
            next_slot();
        end

        repeat (n_tail) begin
            next_slot();
        end
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== files.f ====
source/fetch_pkg.sv
source/fetch_ctrl.sv
source/pc_gen.sv
source/ifid_reg.sv
source/jal_predecode.sv
source/fetch_stage.sv
test/tb_fetch_stage.sv

// ==== Bender.yml ====
package:
  name: fetch_stage

sources:
  - files:
      - source/fetch_pkg.sv
      - source/fetch_ctrl.sv
      - source/pc_gen.sv
      - source/ifid_reg.sv
      - source/jal_predecode.sv
      - source/fetch_stage.sv

  - target: test
    files:
      - test/tb_fetch_stage.sv
